/* rtl/fwd_pkg.sv */
`default_nettype none

package fwd_pkg;

localparam int XLEN       = 64;
localparam int REG_ADDR_W = 5;
localparam int OPCODE_W   = 7;

typedef logic [XLEN-1:0]       xlen_t;
typedef logic [REG_ADDR_W-1:0] reg_addr_t;
typedef logic [OPCODE_W-1:0]   opcode_t;

localparam opcode_t OPC_BRANCH = 7'b1100011;  // BEQ, BNE, BLT, BGE, BLTU, BGEU

// Register usage of one instruction in flight
typedef struct packed {
    reg_addr_t dest;
    reg_addr_t src1;
    reg_addr_t src2;
    logic      is_load;
} stage_regs_t;

typedef struct packed {
    xlen_t alu_a;
    xlen_t alu_b;
    xlen_t jbl_data1;      // Branch compare operand 1
    xlen_t jbl_data2;      // Branch compare operand 2
    xlen_t jbl_addr;       // Jump/branch base address
    xlen_t dm_write_data;  // Store data
} operand_set_t;

typedef struct packed {
    xlen_t alu_result;    // ALU output of the execute stage
    xlen_t dm_read_data;  // Load data in memory access
    xlen_t dm_bypass;     // ALU result carried into memory access
} fwd_data_t;

typedef enum logic [1:0] {
    FWD_RF      = 2'd0,
    FWD_MEM_DM  = 2'd1,
    FWD_EX_ALU  = 2'd2,
    FWD_MEM_ALU = 2'd3
} fwd_src_e;

typedef enum logic [1:0] {
    ST_RUN        = 2'd0,
    ST_HOLD_BOTH  = 2'd1,
    ST_HOLD_FETCH = 2'd2
} stall_state_e;

endpackage

`default_nettype wire

/* rtl/stage_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

// Keeps the register numbers of the three youngest instructions
// Slot 0 is decode, slot 1 execute, slot 2 memory access
module stage_tracker (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire fwd_pkg::stage_regs_t  new_regs,  // Instruction entering decode
    output fwd_pkg::stage_regs_t [2:0] stages
);

// Decode slot takes the new instruction on every edge
// Older slots simply age by one stage
// A stall does not hold them because decode repeats its instruction instead
always_ff @(posedge clk) begin : shift_slots
    if (rst) begin
        stages <= '0;  // All x0 so nothing can match
    end else begin
        stages[0] <= new_regs;
        for (int i = 1; i < 3; i++) begin
            stages[i] <= stages[i-1];
        end
    end
end : shift_slots

endmodule

`default_nettype wire

/* rtl/hazard_detect.sv */
`timescale 1ns/1ps
`default_nettype none

// RAW check of the decode sources against execute and memory destinations
module hazard_detect (
    input  wire fwd_pkg::stage_regs_t [2:0] stages,
    output fwd_pkg::fwd_src_e               sel_a,
    output fwd_pkg::fwd_src_e               sel_b,
    output logic                            load_use
);

fwd_pkg::stage_regs_t dec_slot;
fwd_pkg::stage_regs_t ex_slot;
fwd_pkg::stage_regs_t mem_slot;

logic ex_hit_a;
logic ex_hit_b;
logic mem_hit_a;
logic mem_hit_b;

// Chooses the data source for one operand
// Execute is the newer producer, so its match is checked first
function automatic fwd_pkg::fwd_src_e pick_src(
    input logic hit_ex,
    input logic ex_load,
    input logic hit_mem,
    input logic mem_load
);
    fwd_pkg::fwd_src_e sel;
    sel = fwd_pkg::FWD_RF;
    if (hit_ex) begin
        if (!ex_load) begin
            sel = fwd_pkg::FWD_EX_ALU;
        end  // A load here has no data yet and the stall covers it
    end else if (hit_mem) begin
        sel = mem_load ? fwd_pkg::FWD_MEM_DM : fwd_pkg::FWD_MEM_ALU;
    end
    return sel;
endfunction

assign dec_slot = stages[0];
assign ex_slot  = stages[1];
assign mem_slot = stages[2];

// x0 is hardwired to zero and never forwards
assign ex_hit_a  = (dec_slot.src1 != '0) && (ex_slot.dest == dec_slot.src1);
assign ex_hit_b  = (dec_slot.src2 != '0) && (ex_slot.dest == dec_slot.src2);
assign mem_hit_a = (dec_slot.src1 != '0) && (mem_slot.dest == dec_slot.src1);
assign mem_hit_b = (dec_slot.src2 != '0) && (mem_slot.dest == dec_slot.src2);

assign sel_a = pick_src(ex_hit_a, ex_slot.is_load, mem_hit_a, mem_slot.is_load);
assign sel_b = pick_src(ex_hit_b, ex_slot.is_load, mem_hit_b, mem_slot.is_load);

// Load result is one cycle too late for the decode instruction
assign load_use = ex_slot.is_load && (ex_hit_a || ex_hit_b);

endmodule

`default_nettype wire

/* rtl/stall_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

// Drops the pipeline flop enables for a load-use hazard
// Sequence is both low for one cycle, then only fetch-to-decode low
module stall_sequencer (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic load_use,
    output logic      f_to_d_enable,  // Fetch to decode flop enable
    output logic      d_to_e_enable   // Decode to execute flop enable
);

fwd_pkg::stall_state_e state_q;
fwd_pkg::stall_state_e state_d;

always_comb begin : next_state
    state_d = fwd_pkg::ST_RUN;
    case (state_q)
        fwd_pkg::ST_RUN: begin
            if (load_use) begin
                state_d = fwd_pkg::ST_HOLD_BOTH;
            end
        end
        fwd_pkg::ST_HOLD_BOTH:  state_d = fwd_pkg::ST_HOLD_FETCH;
        fwd_pkg::ST_HOLD_FETCH: state_d = fwd_pkg::ST_RUN;  // Hazards here are not rearmed
        default:                state_d = fwd_pkg::ST_RUN;
    endcase
end : next_state

// Enables are registered from the next state so they line up with it
always_ff @(posedge clk) begin : state_regs
    if (rst) begin
        state_q       <= fwd_pkg::ST_RUN;
        f_to_d_enable <= 1'b1;
        d_to_e_enable <= 1'b1;
    end else begin
        state_q       <= state_d;
        f_to_d_enable <= (state_d == fwd_pkg::ST_RUN);
        d_to_e_enable <= (state_d != fwd_pkg::ST_HOLD_BOTH);
    end
end : state_regs

endmodule

`default_nettype wire

/* rtl/operand_forward.sv */
`timescale 1ns/1ps
`default_nettype none

// Places forwarded data into the operand fields the decode instruction uses
module operand_forward (
    input  wire fwd_pkg::fwd_src_e     sel_a,
    input  wire fwd_pkg::fwd_src_e     sel_b,
    input  wire fwd_pkg::opcode_t      opcode,    // Of the instruction in decode
    input  wire logic                  is_store,
    input  wire fwd_pkg::operand_set_t dec_ops,   // Operands as read by the decoder
    input  wire fwd_pkg::fwd_data_t    fwd_data,
    output fwd_pkg::operand_set_t      ops
);

fwd_pkg::xlen_t val_a;
fwd_pkg::xlen_t val_b;
logic           is_branch;

// Data behind a forwarding select
function automatic fwd_pkg::xlen_t fwd_value(
    input fwd_pkg::fwd_src_e sel,
    input fwd_pkg::fwd_data_t data
);
    fwd_pkg::xlen_t val;
    case (sel)
        fwd_pkg::FWD_MEM_DM:  val = data.dm_read_data;
        fwd_pkg::FWD_EX_ALU:  val = data.alu_result;
        fwd_pkg::FWD_MEM_ALU: val = data.dm_bypass;
        default:              val = '0;
    endcase
    return val;
endfunction

assign val_a     = fwd_value(sel_a, fwd_data);
assign val_b     = fwd_value(sel_b, fwd_data);
assign is_branch = (opcode == fwd_pkg::OPC_BRANCH);

always_comb begin : operand_mux
    ops = dec_ops;  // Unforwarded fields pass through

    // rs1 feeds the ALU and either the compare or the jump base
    if (sel_a != fwd_pkg::FWD_RF) begin
        ops.alu_a = val_a;
        if (is_branch) begin
            ops.jbl_data1 = val_a;
        end else begin
            ops.jbl_addr = val_a;  // JALR base
        end
    end

    // rs2 feeds the compare and either the ALU or the store data
    if (sel_b != fwd_pkg::FWD_RF) begin
        ops.jbl_data2 = val_b;
        if (sel_b == fwd_pkg::FWD_MEM_DM) begin
            ops.alu_b         = val_b;
            ops.dm_write_data = val_b;
        end else if (is_store) begin
            ops.dm_write_data = val_b;  // ALU b holds the offset for a store
        end else begin
            ops.alu_b = val_b;
        end
    end
end : operand_mux

endmodule

`default_nettype wire

/* rtl/pipeline_control.sv */
`timescale 1ns/1ps
`default_nettype none

// Operand forwarding and load-use stall control for a five-stage RV64 pipeline
module pipeline_control (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire fwd_pkg::stage_regs_t  new_regs,   // Registers of the instruction entering decode
    input  wire fwd_pkg::opcode_t      opcode,
    input  wire logic                  is_store,
    input  wire fwd_pkg::operand_set_t dec_ops,
    input  wire fwd_pkg::fwd_data_t    fwd_data,
    output fwd_pkg::operand_set_t      ops,        // To the decode/execute pipeline register
    output logic                       f_to_d_enable,
    output logic                       d_to_e_enable
);

fwd_pkg::stage_regs_t [2:0] stages;
fwd_pkg::fwd_src_e          sel_a;
fwd_pkg::fwd_src_e          sel_b;
logic                       load_use;

stage_tracker u_stage_tracker (
    .clk      (clk),
    .rst      (rst),
    .new_regs (new_regs),
    .stages   (stages)
);

hazard_detect u_hazard_detect (
    .stages   (stages),
    .sel_a    (sel_a),
    .sel_b    (sel_b),
    .load_use (load_use)
);

stall_sequencer u_stall_sequencer (
    .clk           (clk),
    .rst           (rst),
    .load_use      (load_use),
    .f_to_d_enable (f_to_d_enable),
    .d_to_e_enable (d_to_e_enable)
);

operand_forward u_operand_forward (
    .sel_a    (sel_a),
    .sel_b    (sel_b),
    .opcode   (opcode),
    .is_store (is_store),
    .dec_ops  (dec_ops),
    .fwd_data (fwd_data),
    .ops      (ops)
);

endmodule

`default_nettype wire

/* dv/tb_pipeline_control.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_control;

localparam fwd_pkg::opcode_t OPC_JALR = 7'b1100111;
localparam fwd_pkg::opcode_t OPC_OP   = 7'b0110011;

logic                  clk = 1'b0;
logic                  rst;
fwd_pkg::stage_regs_t  new_regs;
fwd_pkg::opcode_t      opcode;
logic                  is_store;
fwd_pkg::operand_set_t dec_ops;
fwd_pkg::fwd_data_t    fwd_data;
fwd_pkg::operand_set_t ops;
logic                  f_to_d_enable;
logic                  d_to_e_enable;

int errors   = 0;
int timeouts = 0;

// Reference state
fwd_pkg::stage_regs_t  applied[$];          // Newest first, three deep
fwd_pkg::stage_regs_t  m_dec;
fwd_pkg::stage_regs_t  m_ex;
fwd_pkg::stage_regs_t  m_mem;
fwd_pkg::stall_state_e m_state;
fwd_pkg::fwd_src_e     exp_sel_a;
fwd_pkg::fwd_src_e     exp_sel_b;
fwd_pkg::operand_set_t exp_ops;
logic                  exp_load_use;
logic                  exp_f2d;
logic                  exp_d2e;
fwd_pkg::opcode_t      pend_opc   = OPC_OP;  // Opcode of the instruction now heading into decode
logic                  pend_store = 1'b0;

pipeline_control u_dut (
    .clk           (clk),
    .rst           (rst),
    .new_regs      (new_regs),
    .opcode        (opcode),
    .is_store      (is_store),
    .dec_ops       (dec_ops),
    .fwd_data      (fwd_data),
    .ops           (ops),
    .f_to_d_enable (f_to_d_enable),
    .d_to_e_enable (d_to_e_enable)
);

always #50 clk = ~clk;

// Newest older producer of src wins and x0 never forwards
function automatic fwd_pkg::fwd_src_e operand_source(
    input fwd_pkg::reg_addr_t   src,
    input fwd_pkg::stage_regs_t ex,
    input fwd_pkg::stage_regs_t mem
);
    if (src == '0) return fwd_pkg::FWD_RF;
    if (ex.dest == src) return ex.is_load ? fwd_pkg::FWD_RF : fwd_pkg::FWD_EX_ALU;
    if (mem.dest == src) return mem.is_load ? fwd_pkg::FWD_MEM_DM : fwd_pkg::FWD_MEM_ALU;
    return fwd_pkg::FWD_RF;
endfunction

function automatic fwd_pkg::xlen_t source_value(
    input fwd_pkg::fwd_src_e  sel,
    input fwd_pkg::fwd_data_t fd
);
    case (sel)
        fwd_pkg::FWD_EX_ALU:  return fd.alu_result;
        fwd_pkg::FWD_MEM_ALU: return fd.dm_bypass;
        fwd_pkg::FWD_MEM_DM:  return fd.dm_read_data;
        default:              return '0;
    endcase
endfunction

function automatic fwd_pkg::operand_set_t expected_ops(
    input fwd_pkg::fwd_src_e     sa,
    input fwd_pkg::fwd_src_e     sb,
    input fwd_pkg::opcode_t      opc,
    input logic                  st,
    input fwd_pkg::operand_set_t din,
    input fwd_pkg::fwd_data_t    fd
);
    fwd_pkg::operand_set_t r;
    r = din;
    if (sa != fwd_pkg::FWD_RF) begin
        r.alu_a = source_value(sa, fd);
        if (opc == fwd_pkg::OPC_BRANCH) r.jbl_data1 = source_value(sa, fd);
        else r.jbl_addr = source_value(sa, fd);
    end
    if (sb != fwd_pkg::FWD_RF) begin
        r.jbl_data2 = source_value(sb, fd);
        if (sb == fwd_pkg::FWD_MEM_DM || !st) r.alu_b = source_value(sb, fd);
        if (sb == fwd_pkg::FWD_MEM_DM || st) r.dm_write_data = source_value(sb, fd);
    end
    return r;
endfunction

function automatic fwd_pkg::stage_regs_t make_regs(
    input int dest,
    input int src1,
    input int src2,
    input bit load
);
    fwd_pkg::stage_regs_t r;
    r.dest    = fwd_pkg::reg_addr_t'(dest);
    r.src1    = fwd_pkg::reg_addr_t'(src1);
    r.src2    = fwd_pkg::reg_addr_t'(src2);
    r.is_load = load;
    return r;
endfunction

always @(posedge clk) begin : model_slots
    if (rst) begin
        applied = '{'0, '0, '0};
    end else begin
        applied.push_front(new_regs);
        void'(applied.pop_back());
    end
    m_dec <= applied[0];
    m_ex  <= applied[1];
    m_mem <= applied[2];
end : model_slots

always_comb begin : expect_calc
    exp_sel_a    = operand_source(m_dec.src1, m_ex, m_mem);
    exp_sel_b    = operand_source(m_dec.src2, m_ex, m_mem);
    exp_ops      = expected_ops(exp_sel_a, exp_sel_b, opcode, is_store, dec_ops, fwd_data);
    exp_load_use = m_ex.is_load && ((m_dec.src1 != '0 && m_ex.dest == m_dec.src1) ||
                                    (m_dec.src2 != '0 && m_ex.dest == m_dec.src2));
end : expect_calc

// Both low one cycle, then fetch held one more cycle
always @(posedge clk) begin : model_stall
    if (rst) begin
        m_state <= fwd_pkg::ST_RUN;
        exp_f2d <= 1'b1;
        exp_d2e <= 1'b1;
    end else begin
        case (m_state)
            fwd_pkg::ST_RUN: begin
                if (exp_load_use) begin
                    m_state <= fwd_pkg::ST_HOLD_BOTH;
                    exp_f2d <= 1'b0;
                    exp_d2e <= 1'b0;
                end
            end
            fwd_pkg::ST_HOLD_BOTH: begin
                m_state <= fwd_pkg::ST_HOLD_FETCH;
                exp_d2e <= 1'b1;
            end
            default: begin
                m_state <= fwd_pkg::ST_RUN;
                exp_f2d <= 1'b1;
                exp_d2e <= 1'b1;
            end
        endcase
    end
end : model_stall

ops_check: assert property (@(negedge clk) disable iff (rst) ops == exp_ops)
    else begin
        errors++;
        $display("** Error at %0t: ops expected %h actual %h", $time, exp_ops, ops);
    end

load_use_check: assert property (@(negedge clk) disable iff (rst)
    u_dut.load_use == exp_load_use)
    else begin
        errors++;
        $display("** Error at %0t: load_use expected %b actual %b", $time, exp_load_use,
                 u_dut.load_use);
    end

f2d_check: assert property (@(negedge clk) disable iff (rst) f_to_d_enable == exp_f2d)
    else begin
        errors++;
        $display("** Error at %0t: f_to_d_enable expected %b actual %b (state %s)", $time,
                 exp_f2d, f_to_d_enable, m_state.name());
    end

d2e_check: assert property (@(negedge clk) disable iff (rst) d_to_e_enable == exp_d2e)
    else begin
        errors++;
        $display("** Error at %0t: d_to_e_enable expected %b actual %b (state %s)", $time,
                 exp_d2e, d_to_e_enable, m_state.name());
    end

task automatic randomize_data();
    for (int i = 0; i < 6; i++) begin
        dec_ops[i*64 +: 64] = {$urandom, $urandom};
    end
    for (int i = 0; i < 3; i++) begin
        fwd_data[i*64 +: 64] = {$urandom, $urandom};
    end
endtask

// Opcode and store flag trail new_regs by one cycle, matching the decode slot
task automatic drive_cycle(
    input fwd_pkg::stage_regs_t regs,
    input fwd_pkg::opcode_t     opc,
    input logic                 st
);
    @(posedge clk);
    #1;
    opcode     = pend_opc;
    is_store   = pend_store;
    pend_opc   = opc;
    pend_store = st;
    new_regs   = regs;
    randomize_data();
endtask

task automatic wait_for_enables(input logic f2d, input logic d2e, input int limit);
    int n;
    n = 0;
    while (!(f_to_d_enable == f2d && d_to_e_enable == d2e)) begin
        if (n == limit) begin
            timeouts++;
            $display("Timeout at %0t: enables never reached f2d=%b d2e=%b within %0d cycles",
                     $time, f2d, d2e, limit);
            break;
        end
        drive_cycle(make_regs(0, 0, 0, 0), OPC_OP, 1'b0);
        n++;
    end
endtask

initial begin : stimulus
    void'($urandom(19006));
    rst      = 1'b1;
    new_regs = '0;
    opcode   = OPC_OP;
    is_store = 1'b0;
    dec_ops  = '0;
    fwd_data = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    repeat (3) drive_cycle(make_regs(0, 0, 0, 0), OPC_OP, 1'b0);  // Pass-through only

    drive_cycle(make_regs(5, 1, 2, 0), OPC_OP, 1'b0);
    drive_cycle(make_regs(9, 5, 5, 0), fwd_pkg::OPC_BRANCH, 1'b0);  // Execute match
    drive_cycle(make_regs(0, 5, 0, 0), OPC_JALR, 1'b0);             // Memory match
    drive_cycle(make_regs(3, 0, 0, 0), OPC_OP, 1'b0);
    drive_cycle(make_regs(3, 0, 0, 0), OPC_OP, 1'b0);
    drive_cycle(make_regs(0, 3, 3, 0), OPC_OP, 1'b1);   // Newest producer wins
    drive_cycle(make_regs(0, 0, 0, 0), OPC_OP, 1'b0);
    drive_cycle(make_regs(0, 0, 0, 0), fwd_pkg::OPC_BRANCH, 1'b1);  // x0 stays put
    drive_cycle(make_regs(4, 1, 1, 1), OPC_OP, 1'b0);
    drive_cycle(make_regs(0, 0, 0, 0), OPC_OP, 1'b0);
    drive_cycle(make_regs(0, 1, 4, 0), OPC_OP, 1'b1);   // Load data to all rs2 users
    drive_cycle(make_regs(0, 0, 0, 0), OPC_OP, 1'b0);

    // Load-use, then a second hazard while the first stall runs
    drive_cycle(make_regs(7, 0, 0, 1), OPC_OP, 1'b0);
    drive_cycle(make_regs(2, 7, 0, 1), fwd_pkg::OPC_BRANCH, 1'b0);
    drive_cycle(make_regs(0, 2, 0, 0), OPC_OP, 1'b0);
    wait_for_enables(1'b0, 1'b0, 6);
    wait_for_enables(1'b1, 1'b1, 6);

    repeat (2000) begin
        drive_cycle(make_regs($urandom_range(0, 7), $urandom_range(0, 7),
                              $urandom_range(0, 7), $urandom_range(0, 3) == 0),
                    ($urandom_range(0, 1) == 0) ? fwd_pkg::OPC_BRANCH : OPC_JALR,
                    1'($urandom_range(0, 1)));
    end
    drive_cycle(make_regs(0, 0, 0, 0), OPC_OP, 1'b0);
    @(posedge clk);

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
        $display("Simulation PASSED");
    end else begin
        $display("Simulation FAILED");
    end
    $finish;
end : stimulus

endmodule

`default_nettype wire

/* sim.f */
rtl/fwd_pkg.sv
rtl/stage_tracker.sv
rtl/hazard_detect.sv
rtl/stall_sequencer.sv
rtl/operand_forward.sv
rtl/pipeline_control.sv
dv/tb_pipeline_control.sv

/* Makefile */
TOP := tb_pipeline_control

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir
